/* common/rram_pkg.sv */
package rram_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sizes

	localparam int ARRAY_SIZE   = 16;                 // Rows, also columns
	localparam int HALF_SIZE    = ARRAY_SIZE / 2;     // Columns sensed per read
	localparam int IM_DEPTH     = 128;
	localparam int OB_DEPTH     = 128;
	localparam int INSTR_WIDTH  = 32;
	localparam int INDEX_WIDTH  = $clog2(ARRAY_SIZE);

	////////////////////////////////////////////////////////////////////////////
	// Instruction fields

	localparam int OPCODE_WIDTH = 4;
	localparam int OPCODE_LSB   = 28;
	localparam int WR_COL_LSB   = 0;
	localparam int WR_ROW_LSB   = 4;
	localparam int WR_DATA_BIT  = 8;                  // 1 is SET, 0 is RESET
	localparam int RD_HALF_BIT  = 0;                  // 1 selects columns 15..8
	localparam int RD_ROW_LSB   = 1;

	////////////////////////////////////////////////////////////////////////////
	// Types

	typedef logic [INSTR_WIDTH-1:0]         instr_t;
	typedef logic [$clog2(IM_DEPTH)-1:0]    im_addr_t;
	typedef logic [$clog2(OB_DEPTH)-1:0]    ob_addr_t;
	typedef logic [$clog2(OB_DEPTH):0]      ob_count_t;
	typedef logic [ARRAY_SIZE-1:0]          line_t;
	typedef logic [ARRAY_SIZE-1:0]          result_t;
	typedef logic [INDEX_WIDTH-1:0]         index_t;

	// Unlisted codes run as idle
	typedef enum logic [OPCODE_WIDTH-1:0] {
		OP_IDLE  = 4'd0,
		OP_WRITE = 4'd1,
		OP_READ  = 4'd2
	} opcode_t;

	typedef enum logic [1:0] {
		S_REST,
		S_PRECHARGE,
		S_SENSE,
		S_STORE
	} drv_state_t;

	// Both line inputs high ties a line to ground
	localparam line_t LINE_REST = '1;

endpackage

/* compile.f */
common/rram_pkg.sv
verilog/instr_mem.sv
controller/instr_fetch.sv
controller/array_driver.sv
verilog/result_buffer.sv
verilog/rram_ctrl.sv
test/rram_array_model.sv
test/rram_ctrl_props.sv
test/rram_ctrl_tb.sv

/* controller/array_driver.sv */
`timescale 1ns/10ps

module array_driver (
	input  logic              clk,
	input  logic              rst,
	input  logic              op_valid,
	input  rram_pkg::instr_t  op_word,
	input  rram_pkg::result_t csa,
	output logic              op_done,
	output logic              res_wr,
	output rram_pkg::result_t res_data,
	output rram_pkg::line_t   in0_bl,
	output rram_pkg::line_t   in1_bl,
	output rram_pkg::line_t   in0_sl,
	output rram_pkg::line_t   in1_sl,
	output rram_pkg::line_t   in0_wl,
	output rram_pkg::line_t   in1_wl,
	output logic              enable_wl,
	output logic              enable_sl,
	output logic              enable_bl,
	output logic              pre,
	output logic              saen_csa,
	output logic              col_select
);
	import rram_pkg::*;

	drv_state_t state;
	opcode_t    opcode;
	index_t     wr_col;
	index_t     wr_row;
	index_t     rd_row;
	logic       wr_data;
	logic       rd_half;
	line_t      col_hot;
	line_t      wr_row_hot;
	line_t      rd_row_hot;
	line_t      half_hot;

	function automatic line_t one_hot(input index_t idx);
		line_t vec;
		for (int i = 0; i < ARRAY_SIZE; i++) begin
			vec[i] = (i == idx);
		end
		return vec;
	endfunction

	// Marks the columns of the lower or upper half
	function automatic line_t half_mask(input logic upper);
		line_t vec;
		for (int i = 0; i < ARRAY_SIZE; i++) begin
			vec[i] = ((i >= HALF_SIZE) == upper);
		end
		return vec;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Field decode

	assign opcode     = opcode_t'(op_word[OPCODE_LSB +: OPCODE_WIDTH]);
	assign wr_col     = op_word[WR_COL_LSB +: INDEX_WIDTH];
	assign wr_row     = op_word[WR_ROW_LSB +: INDEX_WIDTH];
	assign wr_data    = op_word[WR_DATA_BIT];
	assign rd_half    = op_word[RD_HALF_BIT];
	assign rd_row     = op_word[RD_ROW_LSB +: INDEX_WIDTH];

	assign col_hot    = one_hot(wr_col);
	assign wr_row_hot = one_hot(wr_row);
	assign rd_row_hot = one_hot(rd_row);
	assign half_hot   = half_mask(rd_half);

	////////////////////////////////////////////////////////////////////////////
	// Line sequencing

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state      <= S_REST;
			op_done    <= 1'b0;
			res_wr     <= 1'b0;
			in0_bl     <= LINE_REST;
			in1_bl     <= LINE_REST;
			in0_sl     <= LINE_REST;
			in1_sl     <= LINE_REST;
			in0_wl     <= LINE_REST;
			in1_wl     <= LINE_REST;
			enable_wl  <= 1'b0;
			enable_sl  <= 1'b0;
			enable_bl  <= 1'b0;
			pre        <= 1'b1;
			saen_csa   <= 1'b0;
			col_select <= 1'b0;
		end else begin
			op_done <= 1'b0;
			res_wr  <= 1'b0;

			// Park everything unless a read is between precharge and sense
			if (state != S_PRECHARGE) begin
				in0_bl    <= LINE_REST;
				in1_bl    <= LINE_REST;
				in0_sl    <= LINE_REST;
				in1_sl    <= LINE_REST;
				in0_wl    <= LINE_REST;
				in1_wl    <= LINE_REST;
				enable_wl <= 1'b0;
				enable_sl <= 1'b0;
				enable_bl <= 1'b0;
				pre       <= 1'b1;
				saen_csa  <= 1'b0;
			end

			case (state)
				S_REST: begin
					if (op_valid) begin
						case (opcode)
							OP_WRITE: begin
								enable_wl <= 1'b1;
								enable_sl <= 1'b1;
								enable_bl <= 1'b1;
								in0_wl    <= ~wr_row_hot;     // Row drive is 01
								if (wr_data) begin            // SET
									in0_bl <= ~col_hot;
									in1_bl <= ~col_hot;
								end else begin                // RESET
									in0_sl <= ~col_hot;
								end
								op_done   <= 1'b1;
							end
							OP_READ: begin
								pre        <= 1'b0;
								in0_wl     <= ~rd_row_hot;
								in1_wl     <= ~rd_row_hot;
								in0_bl     <= ~half_hot;
								col_select <= rd_half;
								state      <= S_PRECHARGE;
							end
							default: op_done <= 1'b1;
						endcase
					end
				end
				S_PRECHARGE: begin
					pre       <= 1'b1;
					enable_wl <= 1'b1;
					enable_bl <= 1'b1;
					saen_csa  <= 1'b1;
					state     <= S_SENSE;
				end
				S_SENSE: begin
					res_wr  <= 1'b1;
					op_done <= 1'b1;
					state   <= S_STORE;
				end
				S_STORE: state <= S_REST;
			endcase
		end
	end

	// Sense amplifier output taken at the end of the sense cycle
	always_ff @(posedge clk) begin
		if (state == S_SENSE) begin
			res_data <= csa;
		end
	end

endmodule

/* controller/instr_fetch.sv */
`timescale 1ns/10ps

module instr_fetch (
	input  logic               clk,
	input  logic               rst,
	input  logic               run,
	input  rram_pkg::im_addr_t start_addr,
	input  rram_pkg::im_addr_t im_count,
	input  rram_pkg::instr_t   fetch_data,
	input  logic               op_done,
	output rram_pkg::im_addr_t fetch_addr,
	output rram_pkg::instr_t   op_word,
	output logic               op_valid,
	output logic               busy,
	output logic               done
);
	import rram_pkg::*;

	typedef enum logic [1:0] {
		F_IDLE,
		F_FETCH,
		F_ISSUE,
		F_WAIT
	} fetch_state_t;

	fetch_state_t state;
	im_addr_t     pc;
	im_addr_t     next_pc;

	assign fetch_addr = pc;
	assign next_pc    = pc + 1'b1;

	////////////////////////////////////////////////////////////////////////////
	// Program counter sequence

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state    <= F_IDLE;
			pc       <= '0;
			op_valid <= 1'b0;
			busy     <= 1'b0;
			done     <= 1'b0;
		end else begin
			op_valid <= 1'b0;
			done     <= 1'b0;
			case (state)
				F_IDLE: begin
					// Start must land inside the loaded program
					if (run && (start_addr < im_count)) begin
						pc    <= start_addr;
						busy  <= 1'b1;
						state <= F_FETCH;
					end
				end
				F_FETCH: state <= F_ISSUE;      // Memory reads pc
				F_ISSUE: begin
					op_valid <= 1'b1;
					state    <= F_WAIT;
				end
				F_WAIT: begin
					if (op_done) begin
						if (next_pc < im_count) begin
							pc    <= next_pc;
							state <= F_FETCH;
						end else begin
							busy  <= 1'b0;
							done  <= 1'b1;
							state <= F_IDLE;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == F_ISSUE) begin
			op_word <= fetch_data;
		end
	end

endmodule

/* test/rram_array_model.sv */
`timescale 1ns/10ps

module rram_array_model (
	input  logic              clk,
	input  logic              rst,
	input  rram_pkg::line_t   in0_bl,
	input  rram_pkg::line_t   in1_bl,
	input  rram_pkg::line_t   in0_sl,
	input  rram_pkg::line_t   in1_sl,
	input  rram_pkg::line_t   in0_wl,
	input  rram_pkg::line_t   in1_wl,
	input  logic              enable_wl,
	input  logic              enable_sl,
	input  logic              enable_bl,
	input  logic              saen_csa,
	output rram_pkg::result_t csa
);
	import rram_pkg::*;

	line_t cells [ARRAY_SIZE];      // One word per row

	// A write pulse lands only when all three line groups are enabled
	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int r = 0; r < ARRAY_SIZE; r++) begin
				cells[r] <= '0;
			end
		end else if (enable_wl && enable_sl && enable_bl) begin
			for (int r = 0; r < ARRAY_SIZE; r++) begin
				for (int c = 0; c < ARRAY_SIZE; c++) begin
					if (!in0_wl[r] && in1_wl[r]) begin
						if (!in0_bl[c] && !in1_bl[c]) begin
							cells[r][c] <= 1'b1;          // SET
						end else if (!in0_sl[c] && in1_sl[c]) begin
							cells[r][c] <= 1'b0;          // RESET
						end
					end
				end
			end
		end
	end

	// Sensed half goes out in the low byte
	always_comb begin
		csa = '0;
		if (saen_csa) begin
			for (int r = 0; r < ARRAY_SIZE; r++) begin
				if (!in0_wl[r] && !in1_wl[r]) begin
					if (!in0_bl[0]) begin
						csa[HALF_SIZE-1:0] = cells[r][HALF_SIZE-1:0];
					end else if (!in0_bl[HALF_SIZE]) begin
						csa[HALF_SIZE-1:0] = cells[r][ARRAY_SIZE-1:HALF_SIZE];
					end
				end
			end
		end
	end

endmodule

/* test/rram_ctrl_props.sv */
`timescale 1ns/10ps

module rram_ctrl_props (
	input logic clk,
	input logic rst,
	input logic busy,
	input logic done,
	input logic pre,
	input logic enable_wl,
	input logic enable_sl,
	input logic enable_bl,
	input logic saen_csa
);

	int fail_count = 0;

	sense_without_sourceline: assert property (@(posedge clk) disable iff (!rst)
		!(saen_csa && enable_sl))
	else begin
		$error("saen_csa is high together with enable_sl");
		fail_count++;
	end

	// Precharge only with every line group disabled
	precharge_lines_off: assert property (@(posedge clk) disable iff (!rst)
		!pre |-> !enable_wl && !enable_sl && !enable_bl)
	else begin
		$error("pre is low while a line enable is high");
		fail_count++;
	end

	done_single_cycle: assert property (@(posedge clk) disable iff (!rst)
		done |=> !done)
	else begin
		$error("done lasted longer than one cycle");
		fail_count++;
	end

	done_with_busy_fall: assert property (@(posedge clk) disable iff (!rst)
		done |-> $fell(busy))
	else begin
		$error("done did not come with the fall of busy");
		fail_count++;
	end

endmodule

bind rram_ctrl rram_ctrl_props props (.*);

/* test/rram_ctrl_tb.sv */
`timescale 1ns/10ps

module rram_ctrl_tb;
	import rram_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int IM_CAPACITY  = IM_DEPTH - 1;   // Words stored before im_full

	logic      clk;
	logic      rst;
	logic      im_clear;
	logic      im_wr;
	instr_t    im_data;
	logic      im_full;
	logic      run;
	im_addr_t  start_addr;
	logic      busy;
	logic      done;
	logic      ob_rd;
	ob_addr_t  ob_addr;
	result_t   ob_data;
	ob_count_t ob_count;
	line_t     in0_bl;
	line_t     in1_bl;
	line_t     in0_sl;
	line_t     in1_sl;
	line_t     in0_wl;
	line_t     in1_wl;
	logic      enable_wl;
	logic      enable_sl;
	logic      enable_bl;
	logic      pre;
	logic      saen_csa;
	logic      col_select;
	result_t   csa;

	instr_t    prog [$];                // Program for the next run
	line_t     ref_cells [ARRAY_SIZE];  // Expected array contents
	int        seed;
	int        watchdog_limit;

	rram_ctrl DUT (.*);
	rram_array_model u_array (.*);

	always #2 clk = ~clk;

	function automatic instr_t encode_write(input index_t row, input index_t col,
			input logic bit_val);
		return {4'd1, 19'd0, bit_val, row, col};
	endfunction

	function automatic instr_t encode_read(input index_t row, input logic half);
		return {4'd2, 23'd0, row, half};
	endfunction

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string test, input string item,
			input logic [31:0] expected, input logic [31:0] actual);
		assert (actual === expected) else begin
			stop_with_error($sformatf("error %s %s: expected %0h, actual %0h",
				test, item, expected, actual));
		end
	endtask

	task automatic check_rest(input string test);
		check_value(test, "bitlines", '1, {in0_bl, in1_bl});
		check_value(test, "sourcelines", '1, {in0_sl, in1_sl});
		check_value(test, "wordlines", '1, {in0_wl, in1_wl});
		check_value(test, "enables saen pre", 32'h1,
			{enable_wl, enable_sl, enable_bl, saen_csa, pre});
	endtask

	task automatic compare_array(input string test);
		for (int r = 0; r < ARRAY_SIZE; r++) begin
			check_value(test, $sformatf("array row %0d", r), ref_cells[r], u_array.cells[r]);
		end
	endtask

	task automatic load_program(input string test);
		@(posedge clk);
		im_clear <= 1'b1;
		@(posedge clk);
		im_clear <= 1'b0;
		foreach (prog[i]) begin
			im_wr   <= 1'b1;
			im_data <= prog[i];
			@(posedge clk);
		end
		im_wr <= 1'b0;
		watchdog_limit += prog.size() * 16 + 64;
		@(negedge clk);
		check_value(test, "im_full", prog.size() >= IM_CAPACITY, im_full);
	endtask

	task automatic read_result(input int addr, output result_t data);
		@(posedge clk);
		ob_rd   <= 1'b1;
		ob_addr <= ob_addr_t'(addr);
		@(posedge clk);
		ob_rd <= 1'b0;
		@(negedge clk);
		data = ob_data;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Run a program and check every result against the reference array

	task automatic run_program(input string test, input int start);
		result_t expected [$];
		logic    halves [$];
		instr_t  w;
		result_t data;
		int      stored;
		stored = (prog.size() < IM_CAPACITY) ? prog.size() : IM_CAPACITY;
		for (int i = start; i < stored; i++) begin
			w = prog[i];
			case (w[31:28])
				4'd1: ref_cells[w[7:4]][w[3:0]] = w[8];
				4'd2: begin
					expected.push_back(w[0] ? {8'd0, ref_cells[w[4:1]][15:8]}
						: {8'd0, ref_cells[w[4:1]][7:0]});
					halves.push_back(w[0]);
				end
				default: ;                         // Anything else is idle
			endcase
		end
		load_program(test);
		@(posedge clk);
		run        <= 1'b1;
		start_addr <= im_addr_t'(start);
		@(posedge clk);
		run <= 1'b0;
		@(negedge clk);
		check_value(test, "busy after run", 1, busy);
		while (!done) begin
			if (!pre || saen_csa) begin           // Precharge or sense of a read
				assert (halves.size() > 0) else begin
					stop_with_error({test, " saw a read cycle that no READ explains"});
				end
				check_value(test, "col_select", halves[0], col_select);
				if (saen_csa) begin
					void'(halves.pop_front());
				end
			end
			@(negedge clk);
		end
		check_value(test, "busy at done", 0, busy);
		check_value(test, "reads left unsensed", 0, halves.size());
		check_value(test, "ob_count", expected.size(), ob_count);
		foreach (expected[i]) begin
			read_result(i, data);
			check_value(test, $sformatf("ob_data[%0d]", i), expected[i], data);
		end
		compare_array(test);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests

	task automatic check_reset_state();
		@(negedge clk);
		check_rest("reset_state");
		check_value("reset_state", "busy", 0, busy);
		check_value("reset_state", "ob_count", 0, ob_count);
	endtask

	task automatic set_and_read();
		index_t rows [$];
		index_t row;
		prog.delete();
		for (int i = 0; i < 12; i++) begin
			row = index_t'($random(seed));
			prog.push_back(encode_write(row, index_t'($random(seed)), 1'b1));
			rows.push_back(row);
		end
		foreach (rows[i]) begin
			prog.push_back(encode_read(rows[i], 1'b0));
			prog.push_back(encode_read(rows[i], 1'b1));
		end
		run_program("set_and_read", 0);
	endtask

	task automatic reset_clears_cells();
		index_t row;
		index_t col;
		prog.delete();
		for (int r = 0; r < ARRAY_SIZE; r++) begin
			if (ref_cells[r] != '0) begin
				for (int c = ARRAY_SIZE - 1; c >= 0; c--) begin
					if (ref_cells[r][c]) begin
						col = index_t'(c);            // Lowest set column wins
					end
				end
				prog.push_back(encode_write(index_t'(r), col, 1'b0));
				prog.push_back(encode_read(index_t'(r), 1'b0));
				prog.push_back(encode_read(index_t'(r), 1'b1));
			end
		end
		row = index_t'($random(seed));
		col = index_t'($random(seed));
		prog.push_back(encode_write(row, col, 1'b1));
		prog.push_back(encode_read(row, col[3]));
		prog.push_back(encode_write(row, col, 1'b0));
		prog.push_back(encode_read(row, col[3]));
		run_program("reset_clears", 0);
	endtask

	task automatic idle_leaves_array();
		prog.delete();
		prog.push_back(32'h0);
		for (int i = 3; i < 16; i += 3) begin
			prog.push_back({4'(i), 28'($random(seed))});
		end
		prog.push_back(32'h0000_01ff);            // Idle with write-like fields
		run_program("idle_unknown", 0);
		check_rest("idle_unknown");
	endtask

	task automatic offset_start();
		index_t row;
		index_t col;
		index_t row2;
		row  = index_t'($random(seed));
		col  = index_t'($random(seed));
		row2 = index_t'($random(seed));
		prog.delete();
		prog.push_back(encode_write(row, col, !ref_cells[row][col]));   // Skipped
		prog.push_back(encode_read(row, 1'b1));
		prog.push_back(32'h0);
		prog.push_back(encode_read(row, col[3]));
		prog.push_back(encode_write(row2, index_t'($random(seed)), 1'b1));
		prog.push_back(encode_read(row2, 1'b0));
		prog.push_back(encode_read(row2, 1'b1));
		run_program("offset_start", 3);
	endtask

	// Last word goes in while the memory is already full
	task automatic fill_instr_mem();
		index_t row;
		row = index_t'($random(seed));
		prog.delete();
		for (int i = 0; i < IM_CAPACITY - 1; i++) begin
			prog.push_back(32'h0);
		end
		prog.push_back(encode_read(row, 1'b1));
		prog.push_back(encode_write(row, index_t'($random(seed)), 1'b1));
		run_program("full_memory", IM_CAPACITY - 2);
	endtask

	// Watchdog, also stops on a failed bound property
	initial begin
		int cycles;
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (DUT.props.fail_count != 0) begin
				stop_with_error("a concurrent assertion on the DUT failed");
			end
			if (cycles > watchdog_limit) begin
				stop_with_error("watchdog expired, the DUT never finished a run");
			end
		end
	end

	initial begin
		seed           = 32'h3919;
		watchdog_limit = RESET_CYCLES + 200;
		clk            = 1'b0;
		rst            = 1'b0;
		im_clear       = 1'b0;
		im_wr          = 1'b0;
		im_data        = '0;
		run            = 1'b0;
		start_addr     = '0;
		ob_rd          = 1'b0;
		ob_addr        = '0;
		foreach (ref_cells[r]) begin
			ref_cells[r] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b1;

		check_reset_state();
		set_and_read();
		reset_clears_cells();
		idle_leaves_array();
		offset_start();
		fill_instr_mem();

		repeat (4) @(posedge clk);
		if (DUT.props.fail_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* verilog/instr_mem.sv */
`timescale 1ns/10ps

module instr_mem (
	input  logic               clk,
	input  logic               rst,
	input  logic               im_clear,
	input  logic               im_wr,
	input  rram_pkg::instr_t   im_data,
	input  rram_pkg::im_addr_t fetch_addr,
	output rram_pkg::instr_t   fetch_data,
	output rram_pkg::im_addr_t im_count,
	output logic               im_full
);
	import rram_pkg::*;

	instr_t   mem [IM_DEPTH];
	im_addr_t wr_ptr;
	logic     wr_en;

	// Top slot stays free so the word count fits the address width
	assign im_full  = (wr_ptr == im_addr_t'(IM_DEPTH - 1));
	assign im_count = wr_ptr;
	assign wr_en    = im_wr && !im_full && !im_clear;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr <= '0;
		end else if (im_clear) begin
			wr_ptr <= '0;
		end else if (wr_en) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= im_data;
		end
		fetch_data <= mem[fetch_addr];  // Word valid the cycle after the address
	end

endmodule

/* verilog/result_buffer.sv */
`timescale 1ns/10ps

module result_buffer (
	input  logic                clk,
	input  logic                rst,
	input  logic                run,
	input  logic                res_wr,
	input  rram_pkg::result_t   res_data,
	input  logic                ob_rd,
	input  rram_pkg::ob_addr_t  ob_addr,
	output rram_pkg::result_t   ob_data,
	output rram_pkg::ob_count_t ob_count
);
	import rram_pkg::*;

	result_t  mem [OB_DEPTH];
	ob_addr_t wr_ptr;
	logic     buf_full;
	logic     wr_en;

	assign buf_full = (ob_count == ob_count_t'(OB_DEPTH));
	assign wr_en    = res_wr && !buf_full && !run;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr   <= '0;
			ob_count <= '0;
		end else if (run) begin         // New run starts at address 0
			wr_ptr   <= '0;
			ob_count <= '0;
		end else if (wr_en) begin
			wr_ptr   <= wr_ptr + 1'b1;
			ob_count <= ob_count + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= res_data;
		end
		if (ob_rd) begin
			ob_data <= mem[ob_addr];    // Held until the next host read
		end
	end

endmodule

/* verilog/rram_ctrl.sv */
`timescale 1ns/10ps

module rram_ctrl (
	input  logic                clk,
	input  logic                rst,

	// Host side
	input  logic                im_clear,
	input  logic                im_wr,
	input  rram_pkg::instr_t    im_data,
	output logic                im_full,
	input  logic                run,
	input  rram_pkg::im_addr_t  start_addr,
	output logic                busy,
	output logic                done,
	input  logic                ob_rd,
	input  rram_pkg::ob_addr_t  ob_addr,
	output rram_pkg::result_t   ob_data,
	output rram_pkg::ob_count_t ob_count,

	// Array side
	output rram_pkg::line_t     in0_bl,
	output rram_pkg::line_t     in1_bl,
	output rram_pkg::line_t     in0_sl,
	output rram_pkg::line_t     in1_sl,
	output rram_pkg::line_t     in0_wl,
	output rram_pkg::line_t     in1_wl,
	output logic                enable_wl,
	output logic                enable_sl,
	output logic                enable_bl,
	output logic                pre,            // Active low
	output logic                saen_csa,
	output logic                col_select,
	input  rram_pkg::result_t   csa
);
	import rram_pkg::*;

	im_addr_t fetch_addr;
	instr_t   fetch_data;
	im_addr_t im_count;
	instr_t   op_word;
	logic     op_valid;
	logic     op_done;
	logic     res_wr;
	result_t  res_data;

	instr_mem u_instr_mem (
		.clk        (clk),
		.rst        (rst),
		.im_clear   (im_clear),
		.im_wr      (im_wr),
		.im_data    (im_data),
		.fetch_addr (fetch_addr),
		.fetch_data (fetch_data),
		.im_count   (im_count),
		.im_full    (im_full)
	);

	instr_fetch u_instr_fetch (
		.clk        (clk),
		.rst        (rst),
		.run        (run),
		.start_addr (start_addr),
		.im_count   (im_count),
		.fetch_data (fetch_data),
		.op_done    (op_done),
		.fetch_addr (fetch_addr),
		.op_word    (op_word),
		.op_valid   (op_valid),
		.busy       (busy),
		.done       (done)
	);

	array_driver u_array_driver (
		.clk        (clk),
		.rst        (rst),
		.op_valid   (op_valid),
		.op_word    (op_word),
		.csa        (csa),
		.op_done    (op_done),
		.res_wr     (res_wr),
		.res_data   (res_data),
		.in0_bl     (in0_bl),
		.in1_bl     (in1_bl),
		.in0_sl     (in0_sl),
		.in1_sl     (in1_sl),
		.in0_wl     (in0_wl),
		.in1_wl     (in1_wl),
		.enable_wl  (enable_wl),
		.enable_sl  (enable_sl),
		.enable_bl  (enable_bl),
		.pre        (pre),
		.saen_csa   (saen_csa),
		.col_select (col_select)
	);

	result_buffer u_result_buffer (
		.clk      (clk),
		.rst      (rst),
		.run      (run),
		.res_wr   (res_wr),
		.res_data (res_data),
		.ob_rd    (ob_rd),
		.ob_addr  (ob_addr),
		.ob_data  (ob_data),
		.ob_count (ob_count)
	);

endmodule
